//--- n64_ppu_top.f
source/ppu_pkg.sv
source/vd_demux.sv
source/vinfo_detect.sv
source/gamma_channel.sv
source/video_out_stage.sv
source/n64_ppu_top.sv
sim/n64_ppu_properties.sv
sim/n64_ppu_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the n64 ppu testbench with verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module n64_ppu_tb -f n64_ppu_top.f -Mdir obj_dir -o n64_ppu_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/n64_ppu_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^Result: PASSED$" "$LOG"; then
  echo "simulation passed"
  exit 0
fi
echo "simulation failed"
exit 1

//--- sim/n64_ppu_properties.sv
`timescale 1ns/1ps
`default_nettype none

module n64_ppu_properties (
  input wire logic N64_CLK_i,
  input wire logic rst_n_i,
  input wire logic nVDSYNC_i,
  input wire logic pix_valid_i
);

  int fail_cnt = 0;

  // one strobe per pixel, never back to back
  a_valid_single: assert property (@(posedge N64_CLK_i) disable iff (!rst_n_i)
    pix_valid_i |=> !pix_valid_i)
    else begin
      fail_cnt++;
      $error("pix_valid pulsed in two consecutive cycles");
    end

  // sync byte, then r, g, b
  a_valid_after_sync: assert property (@(posedge N64_CLK_i) disable iff (!rst_n_i)
    !nVDSYNC_i |-> ##4 pix_valid_i)
    else begin
      fail_cnt++;
      $error("pix_valid did not follow the sync byte by four cycles");
    end

  a_valid_in_reset: assert property (@(posedge N64_CLK_i) !rst_n_i |-> !pix_valid_i)
    else begin
      fail_cnt++;
      $error("pix_valid high during reset");
    end

endmodule

bind vd_demux n64_ppu_properties u_props (
  .N64_CLK_i   (N64_CLK_i),
  .rst_n_i     (rst_n_i),
  .nVDSYNC_i   (nVDSYNC_i),
  .pix_valid_i (pix_valid_o)
);

`default_nettype wire

//--- sim/n64_ppu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module n64_ppu_tb;

  import ppu_pkg::*;

  // ============================================================
  // stimulus shape and run length
  // ============================================================
  localparam int CLK_PERIOD   = 100;
  localparam int RESET_CYCLES = 2;
  localparam int BLANK_PIX    = 2;    // nhsync low
  localparam int ACTIVE_PIX   = 8;
  localparam int SHORT_LINES  = 4;    // lines per config field
  localparam int NUM_CONFIGS  = 13;
  localparam int NTSC_LINES   = 263;
  localparam int NTSC_SHORT   = 262;
  localparam int PAL_LINES    = 313;
  localparam int MODE_LINES   = 3 * NTSC_LINES + NTSC_SHORT + 2 * PAL_LINES;
  localparam int TOTAL_LINES  = NUM_CONFIGS * SHORT_LINES + MODE_LINES;
  localparam int TOTAL_VSYNCS = NUM_CONFIGS + 7;
  localparam int TOTAL_DRAINS = NUM_CONFIGS + 3;
  localparam int STIM_CYCLES  = (TOTAL_LINES * (BLANK_PIX + ACTIVE_PIX) + TOTAL_VSYNCS)
                                * SAMPLES_PER_PIXEL + TOTAL_DRAINS * 3 * SAMPLES_PER_PIXEL
                                + RESET_CYCLES + NUM_CONFIGS + 1;
  localparam int TIMEOUT_CYCLES = STIM_CYCLES * 3 / 2;

  // sync words {nvsync, nclamp, nhsync, ncsync}
  localparam logic [SYNC_WIDTH-1:0] ACTIVE_SYNC = 4'b1111;
  localparam logic [SYNC_WIDTH-1:0] BLANK_SYNC  = 4'b1100;
  localparam logic [SYNC_WIDTH-1:0] VSYNC_SYNC  = 4'b0110;

  logic                                      N64_CLK_i;
  logic                                      rst_n_i;
  logic                                      nVDSYNC_i;
  logic [VD_WIDTH-1:0]                       VD_i;
  logic [GAMMA_SEL_WIDTH-1:0]                gamma_sel_i;
  logic                                      color16_i;
  logic                                      sl_en_i;
  logic [SL_STRENGTH_WIDTH-1:0]              sl_strength_i;
  logic                                      VSYNC_o;
  logic                                      HSYNC_o;
  logic                                      DE_o;
  logic [NUM_CHANNELS*COLOR_OUT_WIDTH-1:0]   VD_o;
  logic                                      pal_o;
  logic                                      interlaced_o;

  logic [NUM_CHANNELS*COLOR_OUT_WIDTH-1:0]   exp_q[$];
  logic [GAMMA_SEL_WIDTH-1:0]                cfg_sel;
  logic                                      cfg_c16;
  logic                                      cfg_sl;
  logic [SL_STRENGTH_WIDTH-1:0]              cfg_str;
  integer seed = 2;
  int     line_idx = 0;      // line number since last vsync
  int     tx_count = 0;
  int     rx_count = 0;
  int     hs_falls = 0;
  int     vs_falls = 0;
  int     cycle_cnt = 0;
  int     data_errors = 0;
  int     sync_errors = 0;
  int     check_errors = 0;
  int     prop_errors;
  logic   hsync_prev = 1'b1;
  logic   vsync_prev = 1'b1;

  n64_ppu_top UUT (
    .N64_CLK_i     (N64_CLK_i),
    .rst_n_i       (rst_n_i),
    .nVDSYNC_i     (nVDSYNC_i),
    .VD_i          (VD_i),
    .gamma_sel_i   (gamma_sel_i),
    .color16_i     (color16_i),
    .sl_en_i       (sl_en_i),
    .sl_strength_i (sl_strength_i),
    .VSYNC_o       (VSYNC_o),
    .HSYNC_o       (HSYNC_o),
    .DE_o          (DE_o),
    .VD_o          (VD_o),
    .pal_o         (pal_o),
    .interlaced_o  (interlaced_o)
  );

  initial begin
    N64_CLK_i = 1'b0;
    forever #(CLK_PERIOD / 2) N64_CLK_i = ~N64_CLK_i;
  end

  // ============================================================
  // reference model
  // ============================================================
  function automatic logic [COLOR_OUT_WIDTH-1:0] gamma_ref(
    input logic [VD_WIDTH-1:0] s, input logic [GAMMA_SEL_WIDTH-1:0] sel, input logic c16
  );
    int v;
    int lin;
    v   = c16 ? (int'(s) / 4) * 4 : int'(s);
    lin = v * 2 + v / 64;  // msb appended
    case (sel)
      GAMMA_BRIGHT: lin = lin + (255 - lin) / 4;
      GAMMA_DARK:   lin = lin - lin / 4;
      GAMMA_STRONG: lin = lin + (255 - lin) / 2;
      default:      ;
    endcase
    return COLOR_OUT_WIDTH'(lin);
  endfunction

  function automatic logic [COLOR_OUT_WIDTH-1:0] scanline_ref(
    input logic [COLOR_OUT_WIDTH-1:0] v, input logic odd
  );
    int x;
    x = int'(v);
    if (odd && cfg_sl) begin
      x = x - (x * int'(cfg_str)) / 4;
    end
    return COLOR_OUT_WIDTH'(x);
  endfunction

  function automatic logic [NUM_CHANNELS*COLOR_OUT_WIDTH-1:0] expected_word(
    input logic [VD_WIDTH-1:0] r, g, b, input logic odd
  );
    return {scanline_ref(gamma_ref(r, cfg_sel, cfg_c16), odd),
            scanline_ref(gamma_ref(g, cfg_sel, cfg_c16), odd),
            scanline_ref(gamma_ref(b, cfg_sel, cfg_c16), odd)};
  endfunction

  // ============================================================
  // stimulus tasks
  // ============================================================
  task automatic send_pixel(
    input logic [SYNC_WIDTH-1:0] sync_bits, input logic [VD_WIDTH-1:0] r, g, b
  );
    @(posedge N64_CLK_i);
    nVDSYNC_i <= 1'b0;
    VD_i      <= {{(VD_WIDTH - SYNC_WIDTH){1'b0}}, sync_bits};
    @(posedge N64_CLK_i);
    nVDSYNC_i <= 1'b1;
    VD_i      <= r;
    @(posedge N64_CLK_i);
    VD_i <= g;
    @(posedge N64_CLK_i);
    VD_i <= b;
  endtask

  task automatic send_vsync();
    send_pixel(VSYNC_SYNC, '0, '0, '0);
    line_idx = 0;
  endtask

  task automatic send_lines(input int n);
    logic [VD_WIDTH-1:0] r;
    logic [VD_WIDTH-1:0] g;
    logic [VD_WIDTH-1:0] b;
    for (int l = 0; l < n; l++) begin
      for (int p = 0; p < BLANK_PIX; p++) begin
        send_pixel(BLANK_SYNC, '0, '0, '0);
      end
      for (int p = 0; p < ACTIVE_PIX; p++) begin
        r = VD_WIDTH'($random(seed));
        g = VD_WIDTH'($random(seed));
        b = VD_WIDTH'($random(seed));
        exp_q.push_back(expected_word(r, g, b, line_idx[0]));
        tx_count++;
        send_pixel(ACTIVE_SYNC, r, g, b);
      end
      line_idx++;
    end
  endtask

  // wait for the pipeline to empty, then its fixed latency
  task automatic drain();
    while (exp_q.size() != 0) begin
      @(posedge N64_CLK_i);
    end
    repeat (SAMPLES_PER_PIXEL) @(posedge N64_CLK_i);
  endtask

  task automatic configure(
    input logic [GAMMA_SEL_WIDTH-1:0] sel, input logic c16, input logic sl,
    input logic [SL_STRENGTH_WIDTH-1:0] str
  );
    cfg_sel = sel;
    cfg_c16 = c16;
    cfg_sl  = sl;
    cfg_str = str;
    @(posedge N64_CLK_i);
    gamma_sel_i   <= sel;
    color16_i     <= c16;
    sl_en_i       <= sl;
    sl_strength_i <= str;
  endtask

  task automatic run_config(
    input logic [GAMMA_SEL_WIDTH-1:0] sel, input logic c16, input logic sl,
    input logic [SL_STRENGTH_WIDTH-1:0] str
  );
    configure(sel, c16, sl, str);
    send_vsync();
    send_lines(SHORT_LINES);
    drain();
  endtask

  task automatic check_modes(input logic exp_pal, input logic exp_int);
    @(negedge N64_CLK_i);
    assert (pal_o == exp_pal) else begin
      check_errors++;
      $display("mismatch pal_o expected 0x%0h actual 0x%0h", exp_pal, pal_o);
    end
    assert (interlaced_o == exp_int) else begin
      check_errors++;
      $display("mismatch interlaced_o expected 0x%0h actual 0x%0h", exp_int, interlaced_o);
    end
  endtask

  // ============================================================
  // output comparison, sampled mid cycle
  // ============================================================
  always @(negedge N64_CLK_i) begin : compare
    logic [NUM_CHANNELS*COLOR_OUT_WIDTH-1:0] exp_word;
    if (rst_n_i) begin
      assert (!(DE_o && !(HSYNC_o && VSYNC_o))) else begin
        sync_errors++;
        $display("DE_o was high while a sync output was active");
      end
      if (hsync_prev && !HSYNC_o) begin
        hs_falls++;
      end
      hsync_prev = HSYNC_o;
      if (vsync_prev && !VSYNC_o) begin
        vs_falls++;
      end
      vsync_prev = VSYNC_o;
      if (DE_o) begin
        rx_count++;
        assert (exp_q.size() != 0) else begin
          data_errors++;
          $display("DE_o was high with no pixel expected");
        end
        if (exp_q.size() != 0) begin
          exp_word = exp_q.pop_front();
          assert (VD_o == exp_word) else begin
            data_errors++;
            $display("mismatch VD_o expected 0x%06h actual 0x%06h", exp_word, VD_o);
          end
        end
      end
    end
  end

  initial begin
    while (cycle_cnt < TIMEOUT_CYCLES) begin
      @(posedge N64_CLK_i);
      cycle_cnt++;
    end
    $display("timeout after %0d cycles, %0d pixels still pending", cycle_cnt, exp_q.size());
    $display("Result: FAILED");
    $finish;
  end

  // ============================================================
  // test sequence
  // ============================================================
  initial begin
    rst_n_i       = 1'b0;
    nVDSYNC_i     = 1'b1;
    VD_i          = '0;
    gamma_sel_i   = GAMMA_LINEAR;
    color16_i     = 1'b0;
    sl_en_i       = 1'b0;
    sl_strength_i = '0;
    repeat (RESET_CYCLES) @(posedge N64_CLK_i);
    rst_n_i <= 1'b1;

    run_config(GAMMA_LINEAR, 1'b0, 1'b0, 2'd0);  // plain pass-through
    for (int c = 0; c < 2; c++) begin
      for (int s = 0; s < 4; s++) begin
        run_config(GAMMA_SEL_WIDTH'(s), 1'(c), 1'b0, 2'd0);
      end
    end
    for (int s = 0; s < 4; s++) begin
      run_config(GAMMA_DARK, 1'b0, 1'b1, SL_STRENGTH_WIDTH'(s));
    end

    // mode detection, each vsync closes a field
    configure(GAMMA_BRIGHT, 1'b1, 1'b1, 2'd2);
    send_vsync();
    send_lines(NTSC_LINES);
    send_vsync();
    send_lines(NTSC_LINES);
    send_vsync();
    drain();
    check_modes(1'b0, 1'b0);
    send_lines(PAL_LINES);
    send_vsync();
    send_lines(PAL_LINES);
    send_vsync();
    drain();
    check_modes(1'b1, 1'b0);
    send_lines(NTSC_LINES);
    send_vsync();
    send_lines(NTSC_SHORT);
    send_vsync();
    drain();
    check_modes(1'b0, 1'b1);

    assert (exp_q.size() == 0) else begin
      check_errors++;
      $display("%0d expected pixels never appeared on VD_o", exp_q.size());
    end
    assert (rx_count == tx_count) else begin
      check_errors++;
      $display("mismatch DE_o pixel count expected 0x%0h actual 0x%0h", tx_count, rx_count);
    end
    assert (hs_falls == TOTAL_LINES) else begin
      check_errors++;
      $display("mismatch HSYNC_o falls expected 0x%0h actual 0x%0h", TOTAL_LINES, hs_falls);
    end
    assert (vs_falls == TOTAL_VSYNCS) else begin
      check_errors++;
      $display("mismatch VSYNC_o falls expected 0x%0h actual 0x%0h", TOTAL_VSYNCS, vs_falls);
    end
    prop_errors = UUT.u_demux.u_props.fail_cnt;
    $display("errors: data %0d, sync %0d, checks %0d, properties %0d",
             data_errors, sync_errors, check_errors, prop_errors);
    if (data_errors + sync_errors + check_errors + prop_errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- source/gamma_channel.sv
`timescale 1ns/1ps
`default_nettype none

module gamma_channel (
  input  wire logic                                N64_CLK_i,
  input  wire logic                                rst_n_i,
  input  wire logic                                pix_valid_i,
  input  wire logic                                color16_i,
  input  wire logic [ppu_pkg::GAMMA_SEL_WIDTH-1:0] gamma_sel_i,
  input  wire logic [ppu_pkg::VD_WIDTH-1:0]        sample_i,
  output logic [ppu_pkg::COLOR_OUT_WIDTH-1:0]      color_o
);

  import ppu_pkg::*;

  logic [VD_WIDTH-1:0]        sample_red;
  logic [COLOR_OUT_WIDTH-1:0] lin;
  logic [COLOR_OUT_WIDTH-1:0] lin_inv;  // 255 - L
  logic [COLOR_OUT_WIDTH-1:0] curve;

  // 16 bit mode keeps 5 bits per channel
  assign sample_red = color16_i ? {sample_i[VD_WIDTH-1:2], 2'b00} : sample_i;
  assign lin        = {sample_red, sample_red[VD_WIDTH-1]};
  assign lin_inv    = ~lin;

  always_comb begin
    case (gamma_sel_i)
      GAMMA_LINEAR: curve = lin;
      GAMMA_BRIGHT: curve = lin + (lin_inv >> 2);
      GAMMA_DARK:   curve = lin - (lin >> 2);
      GAMMA_STRONG: curve = lin + (lin_inv >> 1);
      default:      curve = lin;
    endcase
  end

  always_ff @(posedge N64_CLK_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      color_o <= '0;
    end else if (pix_valid_i) begin
      color_o <= curve;
    end
  end

endmodule

`default_nettype wire

//--- source/n64_ppu_top.sv
`timescale 1ns/1ps
`default_nettype none

module n64_ppu_top (
  input  wire logic                                  N64_CLK_i,
  input  wire logic                                  rst_n_i,
  input  wire logic                                  nVDSYNC_i,
  input  wire logic [ppu_pkg::VD_WIDTH-1:0]          VD_i,
  input  wire logic [ppu_pkg::GAMMA_SEL_WIDTH-1:0]   gamma_sel_i,
  input  wire logic                                  color16_i,
  input  wire logic                                  sl_en_i,
  input  wire logic [ppu_pkg::SL_STRENGTH_WIDTH-1:0] sl_strength_i,
  output logic                                       VSYNC_o,
  output logic                                       HSYNC_o,
  output logic                                       DE_o,
  output logic [ppu_pkg::NUM_CHANNELS*ppu_pkg::COLOR_OUT_WIDTH-1:0] VD_o,
  output logic                                       pal_o,
  output logic                                       interlaced_o
);

  import ppu_pkg::*;

  vd_word_t                   vd_word;
  logic                       pix_valid_w;
  logic [SYNC_WIDTH-1:0]      sync_w;
  logic [VD_WIDTH-1:0]        sample_w [NUM_CHANNELS];  // r, g, b
  logic [COLOR_OUT_WIDTH-1:0] color_w  [NUM_CHANNELS];
  logic                       line_odd_w;
  logic                       pix_valid_d;  // aligned with gamma output
  logic [SYNC_WIDTH-1:0]      sync_d;

  assign vd_word = VD_i;

  // ============================================================
  // input demux and video info
  // ============================================================
  vd_demux u_demux (
    .N64_CLK_i   (N64_CLK_i),
    .rst_n_i     (rst_n_i),
    .nVDSYNC_i   (nVDSYNC_i),
    .VD_i        (vd_word),
    .pix_valid_o (pix_valid_w),
    .sync_o      (sync_w),
    .sample_r_o  (sample_w[0]),
    .sample_g_o  (sample_w[1]),
    .sample_b_o  (sample_w[2])
  );

  vinfo_detect u_vinfo (
    .N64_CLK_i    (N64_CLK_i),
    .rst_n_i      (rst_n_i),
    .pix_valid_i  (pix_valid_w),
    .sync_i       (sync_w),
    .line_odd_o   (line_odd_w),
    .pal_o        (pal_o),
    .interlaced_o (interlaced_o)
  );

  // ============================================================
  // gamma per channel
  // ============================================================
  for (genvar ch = 0; ch < NUM_CHANNELS; ch++) begin : g_gamma
    gamma_channel u_gamma (
      .N64_CLK_i   (N64_CLK_i),
      .rst_n_i     (rst_n_i),
      .pix_valid_i (pix_valid_w),
      .color16_i   (color16_i),
      .gamma_sel_i (gamma_sel_i),
      .sample_i    (sample_w[ch]),
      .color_o     (color_w[ch])
    );
  end

  // gamma registers once, so valid and sync follow by one
  always_ff @(posedge N64_CLK_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pix_valid_d <= 1'b0;
      sync_d      <= '1;
    end else begin
      pix_valid_d <= pix_valid_w;
      sync_d      <= sync_w;
    end
  end

  video_out_stage u_out (
    .N64_CLK_i     (N64_CLK_i),
    .rst_n_i       (rst_n_i),
    .pix_valid_i   (pix_valid_d),
    .sync_i        (sync_d),
    .color_r_i     (color_w[0]),
    .color_g_i     (color_w[1]),
    .color_b_i     (color_w[2]),
    .line_odd_i    (line_odd_w),
    .sl_en_i       (sl_en_i),
    .sl_strength_i (sl_strength_i),
    .VSYNC_o       (VSYNC_o),
    .HSYNC_o       (HSYNC_o),
    .DE_o          (DE_o),
    .VD_o          (VD_o)
  );

endmodule

`default_nettype wire

//--- source/ppu_pkg.sv
`default_nettype none

package ppu_pkg;

  // ============================================================
  // widths
  // ============================================================
  localparam int VD_WIDTH          = 7;   // n64 bus byte and one colour sample
  localparam int COLOR_OUT_WIDTH   = 8;
  localparam int NUM_CHANNELS      = 3;   // r, g, b
  localparam int SAMPLES_PER_PIXEL = 4;   // sync, r, g, b
  localparam int LINE_CNT_WIDTH    = 10;
  localparam int SYNC_WIDTH        = 4;
  localparam int GAMMA_SEL_WIDTH   = 2;
  localparam int SL_STRENGTH_WIDTH = 2;
  localparam int PHASE_WIDTH       = $clog2(SAMPLES_PER_PIXEL);

  // sync word bit positions, all active low
  localparam int SYNC_NVSYNC = 3;
  localparam int SYNC_NHSYNC = 1;

  // position of the current byte within one pixel
  localparam logic [PHASE_WIDTH-1:0] PHASE_SYNC = '0;
  localparam logic [PHASE_WIDTH-1:0] PHASE_R    = PHASE_WIDTH'(1);
  localparam logic [PHASE_WIDTH-1:0] PHASE_G    = PHASE_WIDTH'(2);
  localparam logic [PHASE_WIDTH-1:0] PHASE_B    = PHASE_WIDTH'(SAMPLES_PER_PIXEL - 1);

  // ============================================================
  // gamma curves and mode detection
  // ============================================================
  localparam logic [GAMMA_SEL_WIDTH-1:0] GAMMA_LINEAR = 2'd0;
  localparam logic [GAMMA_SEL_WIDTH-1:0] GAMMA_BRIGHT = 2'd1;  // L + (255-L)/4
  localparam logic [GAMMA_SEL_WIDTH-1:0] GAMMA_DARK   = 2'd2;  // L - L/4
  localparam logic [GAMMA_SEL_WIDTH-1:0] GAMMA_STRONG = 2'd3;  // L + (255-L)/2

  // 576i/288p fields carry at least this many lines
  localparam logic [LINE_CNT_WIDTH-1:0] PAL_LINE_THRESHOLD = 10'd288;

  // ============================================================
  // input byte, read as sync word or as colour sample
  // ============================================================
  typedef union packed {
    struct packed {
      logic [VD_WIDTH-SYNC_WIDTH-1:0] unused;
      logic                           nvsync;
      logic                           nclamp;
      logic                           nhsync;
      logic                           ncsync;
    } sync;
    logic [VD_WIDTH-1:0] color;
  } vd_word_t;

endpackage

`default_nettype wire

//--- source/vd_demux.sv
`timescale 1ns/1ps
`default_nettype none

module vd_demux (
  input  wire logic                              N64_CLK_i,
  input  wire logic                              rst_n_i,
  input  wire logic                              nVDSYNC_i,
  input  wire ppu_pkg::vd_word_t                 VD_i,
  output logic                                   pix_valid_o,
  output logic [ppu_pkg::SYNC_WIDTH-1:0]         sync_o,
  output logic [ppu_pkg::VD_WIDTH-1:0]           sample_r_o,
  output logic [ppu_pkg::VD_WIDTH-1:0]           sample_g_o,
  output logic [ppu_pkg::VD_WIDTH-1:0]           sample_b_o
);

  import ppu_pkg::*;

  logic [PHASE_WIDTH-1:0] phase_q;  // phase of the byte now on VD_i

  // phase counter, sync latch and pixel strobe
  // phase 0 while idle means no sync byte seen yet
  always_ff @(posedge N64_CLK_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      phase_q     <= PHASE_SYNC;
      pix_valid_o <= 1'b0;
      sync_o      <= '1;
    end else begin
      pix_valid_o <= 1'b0;
      if (!nVDSYNC_i) begin
        phase_q <= PHASE_R;  // next byte is red
        sync_o  <= {VD_i.sync.nvsync, VD_i.sync.nclamp,
                    VD_i.sync.nhsync, VD_i.sync.ncsync};
      end else if (phase_q != PHASE_SYNC) begin
        phase_q <= phase_q + 1'b1;  // wraps to idle after blue
        if (phase_q == PHASE_B) begin
          pix_valid_o <= 1'b1;
        end
      end
    end
  end

  // colour holding registers
  always_ff @(posedge N64_CLK_i) begin
    if (nVDSYNC_i) begin
      case (phase_q)
        PHASE_R: sample_r_o <= VD_i.color;
        PHASE_G: sample_g_o <= VD_i.color;
        PHASE_B: sample_b_o <= VD_i.color;
        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- source/video_out_stage.sv
`timescale 1ns/1ps
`default_nettype none

module video_out_stage (
  input  wire logic                                  N64_CLK_i,
  input  wire logic                                  rst_n_i,
  input  wire logic                                  pix_valid_i,
  input  wire logic [ppu_pkg::SYNC_WIDTH-1:0]        sync_i,
  input  wire logic [ppu_pkg::COLOR_OUT_WIDTH-1:0]   color_r_i,
  input  wire logic [ppu_pkg::COLOR_OUT_WIDTH-1:0]   color_g_i,
  input  wire logic [ppu_pkg::COLOR_OUT_WIDTH-1:0]   color_b_i,
  input  wire logic                                  line_odd_i,
  input  wire logic                                  sl_en_i,
  input  wire logic [ppu_pkg::SL_STRENGTH_WIDTH-1:0] sl_strength_i,
  output logic                                       VSYNC_o,
  output logic                                       HSYNC_o,
  output logic                                       DE_o,
  output logic [ppu_pkg::NUM_CHANNELS*ppu_pkg::COLOR_OUT_WIDTH-1:0] VD_o
);

  import ppu_pkg::*;

  logic                       sl_active;
  logic                       valid_q;
  logic [SYNC_WIDTH-1:0]      sync_q;
  logic [COLOR_OUT_WIDTH-1:0] r_q;
  logic [COLOR_OUT_WIDTH-1:0] g_q;
  logic [COLOR_OUT_WIDTH-1:0] b_q;

  // V - floor(V * strength / 4)
  function automatic logic [COLOR_OUT_WIDTH-1:0] sl_dim(
    input logic [COLOR_OUT_WIDTH-1:0]   v,
    input logic [SL_STRENGTH_WIDTH-1:0] s
  );
    logic [COLOR_OUT_WIDTH+SL_STRENGTH_WIDTH-1:0] prod;
    prod = v * s;
    return v - COLOR_OUT_WIDTH'(prod >> 2);
  endfunction

  assign sl_active = sl_en_i & line_odd_i;

  // ============================================================
  // scanline stage
  // ============================================================
  always_ff @(posedge N64_CLK_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
      sync_q  <= '1;
    end else begin
      valid_q <= pix_valid_i;
      if (pix_valid_i) begin
        sync_q <= sync_i;
      end
    end
  end

  always_ff @(posedge N64_CLK_i) begin
    if (pix_valid_i) begin
      r_q <= sl_active ? sl_dim(color_r_i, sl_strength_i) : color_r_i;
      g_q <= sl_active ? sl_dim(color_g_i, sl_strength_i) : color_g_i;
      b_q <= sl_active ? sl_dim(color_b_i, sl_strength_i) : color_b_i;
    end
  end

  // ============================================================
  // output registers
  // ============================================================
  always_ff @(posedge N64_CLK_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      VSYNC_o <= 1'b1;
      HSYNC_o <= 1'b1;
      DE_o    <= 1'b0;
      VD_o    <= '0;
    end else begin
      DE_o <= valid_q & (&sync_q);  // active video only
      if (valid_q) begin
        VSYNC_o <= sync_q[SYNC_NVSYNC];
        HSYNC_o <= sync_q[SYNC_NHSYNC];
        VD_o    <= (&sync_q) ? {r_q, g_q, b_q} : '0;  // black in blanking
      end
    end
  end

endmodule

`default_nettype wire

//--- source/vinfo_detect.sv
`timescale 1ns/1ps
`default_nettype none

module vinfo_detect (
  input  wire logic                              N64_CLK_i,
  input  wire logic                              rst_n_i,
  input  wire logic                              pix_valid_i,
  input  wire logic [ppu_pkg::SYNC_WIDTH-1:0]    sync_i,
  output logic                                   line_odd_o,
  output logic                                   pal_o,
  output logic                                   interlaced_o
);

  import ppu_pkg::*;

  logic                      nhsync_prev;
  logic                      nvsync_prev;
  logic                      hs_fall;
  logic                      vs_fall;
  logic                      first_line;  // next hsync starts line 0
  logic [LINE_CNT_WIDTH-1:0] line_cnt;
  logic [LINE_CNT_WIDTH-1:0] prev_cnt;    // lines of the previous field

  assign hs_fall = nhsync_prev & ~sync_i[SYNC_NHSYNC];
  assign vs_fall = nvsync_prev & ~sync_i[SYNC_NVSYNC];

  always_ff @(posedge N64_CLK_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      nhsync_prev  <= 1'b1;
      nvsync_prev  <= 1'b1;
      first_line   <= 1'b1;
      line_cnt     <= '0;
      prev_cnt     <= '0;
      line_odd_o   <= 1'b0;
      pal_o        <= 1'b0;
      interlaced_o <= 1'b0;
    end else if (pix_valid_i) begin
      nhsync_prev <= sync_i[SYNC_NHSYNC];
      nvsync_prev <= sync_i[SYNC_NVSYNC];

      if (vs_fall) begin
        // field ends here
        pal_o        <= (line_cnt >= PAL_LINE_THRESHOLD);
        interlaced_o <= (line_cnt != prev_cnt);  // 262/263 alternation
        prev_cnt     <= line_cnt;
        line_cnt     <= LINE_CNT_WIDTH'(hs_fall);
        line_odd_o   <= 1'b0;
        first_line   <= ~hs_fall;
      end else if (hs_fall) begin
        line_cnt <= line_cnt + 1'b1;
        if (first_line) begin
          first_line <= 1'b0;
        end else begin
          line_odd_o <= ~line_odd_o;
        end
      end
    end
  end

endmodule

`default_nettype wire
